/* src/ooo_params.svh */
`ifndef OOO_PARAMS_SVH
`define OOO_PARAMS_SVH

// architectural register file
`define ARCH_REGS    32
`define REG_LEN      5

// reorder buffer, tag width must cover ROB_DEPTH
`define ROB_DEPTH    8
`define ROB_TAG_LEN  3

// reservation station slots
`define RS_DEPTH     4

`endif

/* src/ooo_pkg.sv */
`include "ooo_params.svh"

package ooo_pkg;

    // invalid tag means value lives in the arch file
    typedef struct packed {
        logic                    valid;
        logic [`ROB_TAG_LEN-1:0] tag;
    } tag_t;

    typedef struct packed {
        logic                valid;
        logic                has_dest;
        logic [`REG_LEN-1:0] dest_idx;
        logic [`REG_LEN-1:0] rs1_idx;
        logic [`REG_LEN-1:0] rs2_idx;
    } dispatch_req_t;

    typedef struct packed {
        logic                    valid;
        logic [`REG_LEN-1:0]     dest_idx;
        logic [`ROB_TAG_LEN-1:0] tag;
    } rename_write_t;

    typedef struct packed {
        tag_t rs1_tag;
        logic rs1_ready;
        tag_t rs2_tag;
        logic rs2_ready;
    } mt_lookup_t;

    typedef struct packed {
        logic                    valid;
        logic [`ROB_TAG_LEN-1:0] tag;
    } cdb_t;

    typedef struct packed {
        logic                    valid;
        logic [`ROB_TAG_LEN-1:0] tag;
        logic                    has_dest;
        logic [`REG_LEN-1:0]     dest_idx;
    } retire_t;

    typedef struct packed {
        logic [`ROB_TAG_LEN-1:0] rob_tag;
        tag_t                    rs1_tag;
        tag_t                    rs2_tag;
    } issue_t;

endpackage

/* src/map_table.sv */
`timescale 1ns/1ps

`include "ooo_params.svh"

module map_table (
    input  logic                   clock,
    input  logic                   arst_n,
    input  logic                   squash,
    input  logic [`REG_LEN-1:0]    rs1_idx,
    input  logic [`REG_LEN-1:0]    rs2_idx,
    input  ooo_pkg::rename_write_t rename_write,
    input  ooo_pkg::cdb_t          cdb,
    input  ooo_pkg::retire_t       retire,
    output ooo_pkg::mt_lookup_t    lookup
);

    ooo_pkg::tag_t          map_tag [`ARCH_REGS];
    logic [`ARCH_REGS-1:0]  map_ready;
    logic                   dup_tag;

    // lookup sees registered state only, so writes show up next cycle
    always_comb begin
        lookup.rs1_tag   = map_tag[rs1_idx];
        lookup.rs1_ready = map_ready[rs1_idx];
        lookup.rs2_tag   = map_tag[rs2_idx];
        lookup.rs2_ready = map_ready[rs2_idx];
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `ARCH_REGS; i++) begin
                map_tag[i]   <= '0;
                map_ready[i] <= 1'b0;
            end
        end else if (squash) begin
            for (int i = 0; i < `ARCH_REGS; i++) begin
                map_tag[i]   <= '0;
                map_ready[i] <= 1'b0;
            end
        end else begin
            for (int i = 0; i < `ARCH_REGS; i++) begin
                if (rename_write.valid && rename_write.dest_idx == `REG_LEN'(i)) begin
                    // new producer overrides wakeup and retire
                    map_tag[i].valid <= 1'b1;
                    map_tag[i].tag   <= rename_write.tag;
                    map_ready[i]     <= 1'b0;
                end else if (map_tag[i].valid) begin
                    if (cdb.valid && map_tag[i].tag == cdb.tag) begin
                        map_ready[i] <= 1'b1; // producer done, value still in rob
                    end
                    if (retire.valid && map_tag[i].tag == retire.tag) begin
                        map_tag[i]   <= '0; // arch file holds it now
                        map_ready[i] <= 1'b0;
                    end
                end
            end
        end
    end

    // pairwise scan for a tag mapped twice
    always_comb begin
        dup_tag = 1'b0;
        for (int i = 0; i < `ARCH_REGS; i++) begin
            for (int j = i + 1; j < `ARCH_REGS; j++) begin
                if (map_tag[i].valid && map_tag[j].valid &&
                    map_tag[i].tag == map_tag[j].tag) begin
                    dup_tag = 1'b1;
                end
            end
        end
    end

    // a tag names one in-flight producer, so at most one register maps to it
    a_unique_tags : assert property (
        @(posedge clock) disable iff (!arst_n)
        !dup_tag
    ) else $error("map_table: tag mapped by more than one register");

endmodule

/* src/reorder_buffer.sv */
`timescale 1ns/1ps

`include "ooo_params.svh"

module reorder_buffer (
    input  logic                    clock,
    input  logic                    arst_n,
    input  logic                    squash,
    input  ooo_pkg::dispatch_req_t  dispatch_req,
    input  logic                    rs_full,
    input  ooo_pkg::cdb_t           cdb,
    output logic                    dispatch_ready,
    output logic                    dispatch_accept,
    output logic [`ROB_TAG_LEN-1:0] alloc_tag,
    output ooo_pkg::rename_write_t  rename_write,
    output ooo_pkg::retire_t        retire
);

    localparam int CNT_LEN = `ROB_TAG_LEN + 1;

    logic [`ROB_TAG_LEN-1:0] head;
    logic [`ROB_TAG_LEN-1:0] tail;
    logic [CNT_LEN-1:0]      count;
    logic [`ROB_DEPTH-1:0]   rob_busy;
    logic [`ROB_DEPTH-1:0]   rob_done;
    logic                    rob_has_dest [`ROB_DEPTH];
    logic [`REG_LEN-1:0]     rob_dest [`ROB_DEPTH];
    logic                    rob_full;
    logic                    head_retire;

    function automatic logic [`ROB_TAG_LEN-1:0] next_ptr(input logic [`ROB_TAG_LEN-1:0] ptr);
        next_ptr = (ptr == `ROB_TAG_LEN'(`ROB_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign rob_full        = (count == CNT_LEN'(`ROB_DEPTH));
    assign dispatch_ready  = !rob_full && !rs_full;
    assign dispatch_accept = dispatch_req.valid && dispatch_ready;
    assign alloc_tag       = tail;

    always_comb begin
        rename_write.valid    = dispatch_accept && dispatch_req.has_dest;
        rename_write.dest_idx = dispatch_req.dest_idx;
        rename_write.tag      = tail;
    end

    // in-order retire, head must have completed on an earlier edge
    assign head_retire = rob_busy[head] && rob_done[head];

    always_comb begin
        retire.valid    = head_retire;
        retire.tag      = head;
        retire.has_dest = rob_has_dest[head];
        retire.dest_idx = rob_dest[head];
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            head     <= '0;
            tail     <= '0;
            count    <= '0;
            rob_busy <= '0;
            rob_done <= '0;
        end else if (squash) begin
            head     <= '0; // allocation restarts at tag 0
            tail     <= '0;
            count    <= '0;
            rob_busy <= '0;
            rob_done <= '0;
        end else begin
            if (dispatch_accept) begin
                rob_busy[tail] <= 1'b1;
                rob_done[tail] <= 1'b0;
                tail           <= next_ptr(tail);
            end
            if (cdb.valid) begin
                rob_done[cdb.tag] <= 1'b1;
            end
            if (head_retire) begin
                rob_busy[head] <= 1'b0;
                rob_done[head] <= 1'b0;
                head           <= next_ptr(head);
            end
            count <= count + CNT_LEN'(dispatch_accept) - CNT_LEN'(head_retire);
        end
    end

    always_ff @(posedge clock) begin
        if (dispatch_accept) begin
            rob_has_dest[tail] <= dispatch_req.has_dest;
            rob_dest[tail]     <= dispatch_req.dest_idx;
        end
    end

    // count and busy bits must agree, tail never lands on a live entry
    a_alloc_free : assert property (
        @(posedge clock) disable iff (!arst_n)
        dispatch_accept |-> !rob_busy[tail]
    ) else $error("reorder_buffer: allocation into a busy entry");

    // completions only for issued, not yet completed tags
    a_cdb_hit : assert property (
        @(posedge clock) disable iff (!arst_n)
        (cdb.valid && !squash) |-> rob_busy[cdb.tag] && !rob_done[cdb.tag]
    ) else $error("reorder_buffer: cdb for idle or completed tag");

endmodule

/* src/reservation_station.sv */
`timescale 1ns/1ps

`include "ooo_params.svh"

module reservation_station (
    input  logic                    clock,
    input  logic                    arst_n,
    input  logic                    squash,
    input  logic                    dispatch_accept,
    input  logic [`ROB_TAG_LEN-1:0] alloc_tag,
    input  ooo_pkg::mt_lookup_t     lookup,
    input  ooo_pkg::cdb_t           cdb,
    output logic                    rs_full,
    output logic                    issue_valid,
    output ooo_pkg::issue_t         issue
);

    localparam int RS_IDX_LEN = $clog2(`RS_DEPTH);

    ooo_pkg::issue_t        slot_op [`RS_DEPTH];
    logic [`RS_DEPTH-1:0]   slot_busy;
    logic [`RS_DEPTH-1:0]   slot_rdy1;
    logic [`RS_DEPTH-1:0]   slot_rdy2;
    logic [RS_IDX_LEN-1:0]  free_sel;
    logic [RS_IDX_LEN-1:0]  issue_sel;
    logic                   in_rdy1;
    logic                   in_rdy2;

    assign rs_full = &slot_busy;

    // source ready: arch file, finished producer, or completing right now
    assign in_rdy1 = !lookup.rs1_tag.valid || lookup.rs1_ready ||
                     (cdb.valid && cdb.tag == lookup.rs1_tag.tag);
    assign in_rdy2 = !lookup.rs2_tag.valid || lookup.rs2_ready ||
                     (cdb.valid && cdb.tag == lookup.rs2_tag.tag);

    // scan downwards so the lowest index wins
    always_comb begin
        free_sel    = '0;
        issue_sel   = '0;
        issue_valid = 1'b0;
        for (int i = `RS_DEPTH - 1; i >= 0; i--) begin
            if (!slot_busy[i]) begin
                free_sel = RS_IDX_LEN'(i);
            end
            if (slot_busy[i] && slot_rdy1[i] && slot_rdy2[i]) begin
                issue_valid = 1'b1;
                issue_sel   = RS_IDX_LEN'(i);
            end
        end
    end

    assign issue = slot_op[issue_sel];

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            slot_busy <= '0;
            slot_rdy1 <= '0;
            slot_rdy2 <= '0;
        end else if (squash) begin
            slot_busy <= '0;
            slot_rdy1 <= '0;
            slot_rdy2 <= '0;
        end else begin
            for (int i = 0; i < `RS_DEPTH; i++) begin
                if (cdb.valid && slot_busy[i]) begin // wakeup
                    if (slot_op[i].rs1_tag.valid && slot_op[i].rs1_tag.tag == cdb.tag) begin
                        slot_rdy1[i] <= 1'b1;
                    end
                    if (slot_op[i].rs2_tag.valid && slot_op[i].rs2_tag.tag == cdb.tag) begin
                        slot_rdy2[i] <= 1'b1;
                    end
                end
            end
            if (issue_valid) begin
                slot_busy[issue_sel] <= 1'b0;
            end
            if (dispatch_accept) begin // free slot never equals issuing slot
                slot_busy[free_sel] <= 1'b1;
                slot_rdy1[free_sel] <= in_rdy1;
                slot_rdy2[free_sel] <= in_rdy2;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (dispatch_accept) begin
            slot_op[free_sel] <= '{rob_tag: alloc_tag,
                                   rs1_tag: lookup.rs1_tag,
                                   rs2_tag: lookup.rs2_tag};
        end
    end

    // the rob may only accept while a slot is free
    a_alloc_slot_free : assert property (
        @(posedge clock) disable iff (!arst_n)
        dispatch_accept |-> !slot_busy[free_sel]
    ) else $error("reservation_station: dispatch into a busy slot");

endmodule

/* src/dispatch_core.sv */
`timescale 1ns/1ps

`include "ooo_params.svh"

module dispatch_core (
    input  logic                   clock,
    input  logic                   arst_n,
    input  logic                   squash,
    input  ooo_pkg::dispatch_req_t dispatch_req,
    input  ooo_pkg::cdb_t          cdb,
    output logic                   dispatch_ready,
    output logic                   issue_valid,
    output ooo_pkg::issue_t        issue,
    output ooo_pkg::retire_t       retire
);

    logic                    rs_full;
    logic                    dispatch_accept;
    logic [`ROB_TAG_LEN-1:0] alloc_tag;
    ooo_pkg::rename_write_t  rename_write;
    ooo_pkg::mt_lookup_t     lookup;

    map_table u_map_table (
        .clock        (clock),
        .arst_n       (arst_n),
        .squash       (squash),
        .rs1_idx      (dispatch_req.rs1_idx),
        .rs2_idx      (dispatch_req.rs2_idx),
        .rename_write (rename_write),
        .cdb          (cdb),
        .retire       (retire),
        .lookup       (lookup)
    );

    reorder_buffer u_reorder_buffer (
        .clock           (clock),
        .arst_n          (arst_n),
        .squash          (squash),
        .dispatch_req    (dispatch_req),
        .rs_full         (rs_full),
        .cdb             (cdb),
        .dispatch_ready  (dispatch_ready),
        .dispatch_accept (dispatch_accept),
        .alloc_tag       (alloc_tag),
        .rename_write    (rename_write),
        .retire          (retire)
    );

    reservation_station u_reservation_station (
        .clock           (clock),
        .arst_n          (arst_n),
        .squash          (squash),
        .dispatch_accept (dispatch_accept),
        .alloc_tag       (alloc_tag),
        .lookup          (lookup), // renamed sources, same cycle
        .cdb             (cdb),
        .rs_full         (rs_full),
        .issue_valid     (issue_valid),
        .issue           (issue)
    );

endmodule

/* tb/dispatch_core_tb.sv */
`timescale 1ns/1ps

`include "ooo_params.svh"

module dispatch_core_tb;

    typedef struct {
        int                  test_id;
        logic                has_dest;
        logic [`REG_LEN-1:0] dest;
        logic [`REG_LEN-1:0] rs1;
        logic [`REG_LEN-1:0] rs2;
        int                  cdb_delay;
        logic                squash_before;
    } row_t;

    logic                    clock = 1'b0;
    logic                    arst_n;
    logic                    squash;
    ooo_pkg::dispatch_req_t  dispatch_req;
    ooo_pkg::cdb_t           cdb;
    logic                    dispatch_ready;
    logic                    issue_valid;
    ooo_pkg::issue_t         issue;
    ooo_pkg::retire_t        retire;

    row_t                    rows [$];
    ooo_pkg::tag_t           shadow_map [`ARCH_REGS]; // expected producer per arch reg
    ooo_pkg::issue_t         exp_issue [`ROB_DEPTH];
    ooo_pkg::retire_t        retire_q [$];            // allocation order
    logic [`ROB_TAG_LEN-1:0] next_tag;
    logic [`ROB_TAG_LEN-1:0] slot_tag [`RS_DEPTH];    // station slots as the model sees them
    logic                    slot_used [`RS_DEPTH];
    logic                    src1_wait [`ROB_DEPTH];
    logic                    src2_wait [`ROB_DEPTH];
    logic                    cdb_seen [`ROB_DEPTH];
    int                      due [`ROB_DEPTH];        // cycle the fu answers, -1 idle
    int                      tag_delay [`ROB_DEPTH];
    logic [31:0]             rng = 32'h78413166;
    logic                    accepted;
    int                      cur_delay;
    int                      cycle = 0;
    int                      cycle_limit = 0;
    int                      watch_cycles = 0;
    int                      errors = 0;
    int                      passed = 0;
    int                      failed = 0;
    int                      rob_cnt;
    int                      rs_cnt;
    int                      rs_stalls = 0;
    int                      rob_stalls = 0;
    string                   test_name [6] = '{"idle after reset", "independent tags",
        "dependency renaming", "in-order retire", "dispatch back-pressure", "squash"};

    dispatch_core dut (
        .clock          (clock),
        .arst_n         (arst_n),
        .squash         (squash),
        .dispatch_req   (dispatch_req),
        .cdb            (cdb),
        .dispatch_ready (dispatch_ready),
        .issue_valid    (issue_valid),
        .issue          (issue),
        .retire         (retire)
    );

    always #2 clock = ~clock;

    always @(posedge clock) begin
        if (arst_n) begin
            watch_cycles = watch_cycles + 1;
        end
        if (watch_cycles > cycle_limit) begin
            $display("timeout: run still busy after %0d cycles", watch_cycles);
            $display("Test failed");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic void add_row(input int id, input logic has_dest, input int dest,
                                    input int rs1, input int rs2, input int delay,
                                    input logic sq);
        rows.push_back('{id, has_dest, `REG_LEN'(dest), `REG_LEN'(rs1), `REG_LEN'(rs2),
                         delay, sq});
    endfunction

    task automatic report_error(input logic wrong_value, input string msg);
        errors++;
        if (wrong_value) begin
            $display("[FAIL] t=%0t %s", $realtime, msg);
        end else begin
            $display("error at t=%0t: %s", $realtime, msg);
        end
    endtask

    task automatic compare_tag(input ooo_pkg::tag_t got, input ooo_pkg::tag_t exp,
                               input string what);
        // tag bits of an invalid tag carry no meaning
        if (got.valid !== exp.valid || (exp.valid && got.tag !== exp.tag)) begin
            report_error(1'b1, $sformatf("%s got v%0b/%0d expected v%0b/%0d", what,
                                         got.valid, got.tag, exp.valid, exp.tag));
        end
    endtask

    task automatic compare_issue(input ooo_pkg::issue_t got, input ooo_pkg::issue_t exp);
        if (got.rob_tag !== exp.rob_tag) begin
            report_error(1'b1, $sformatf("issue tag %0d expected %0d", got.rob_tag, exp.rob_tag));
        end
        compare_tag(got.rs1_tag, exp.rs1_tag, $sformatf("issue %0d rs1", exp.rob_tag));
        compare_tag(got.rs2_tag, exp.rs2_tag, $sformatf("issue %0d rs2", exp.rob_tag));
    endtask

    task automatic compare_retire(input ooo_pkg::retire_t got, input ooo_pkg::retire_t exp);
        if (got !== exp) begin
            report_error(1'b1, $sformatf(
                "retire tag %0d dest %0b/%0d expected tag %0d dest %0b/%0d",
                got.tag, got.has_dest, got.dest_idx, exp.tag, exp.has_dest, exp.dest_idx));
        end
    endtask

    task automatic compare_ready(input logic got, input logic exp);
        if (got !== exp) begin
            report_error(1'b1, $sformatf("dispatch_ready %0b expected %0b", got, exp));
        end
    endtask

    task automatic clear_model();
        for (int i = 0; i < `ARCH_REGS; i++) begin
            shadow_map[i] = '0;
        end
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            cdb_seen[i] = 1'b0;
            due[i]      = -1;
        end
        for (int i = 0; i < `RS_DEPTH; i++) begin
            slot_used[i] = 1'b0;
        end
        retire_q.delete();
        next_tag = '0;
        rob_cnt  = 0;
        rs_cnt   = 0;
    endtask

    // one clock: check outputs at the falling edge, then drive the fu answer
    task automatic run_cycle();
        ooo_pkg::tag_t           look1;
        ooo_pkg::tag_t           look2;
        ooo_pkg::retire_t        exp_ret;
        logic [`ROB_TAG_LEN-1:0] t;
        int                      pick;
        int                      exp_slot;
        int                      free_slot;
        @(negedge clock);
        cycle++;
        compare_ready(dispatch_ready, rob_cnt < `ROB_DEPTH && rs_cnt < `RS_DEPTH);
        if (dispatch_req.valid && !dispatch_ready) begin
            rs_stalls  += int'(rs_cnt == `RS_DEPTH);
            rob_stalls += int'(rob_cnt == `ROB_DEPTH);
        end
        look1 = shadow_map[dispatch_req.rs1_idx]; // before this cycle's updates
        look2 = shadow_map[dispatch_req.rs2_idx];
        exp_slot  = -1;
        free_slot = -1;
        for (int i = 0; i < `RS_DEPTH; i++) begin
            if (!slot_used[i] && free_slot < 0) begin
                free_slot = i; // next dispatch lands here
            end
            if (slot_used[i] && exp_slot < 0 && !src1_wait[slot_tag[i]] &&
                !src2_wait[slot_tag[i]]) begin
                exp_slot = i; // lowest slot with both operands awake
            end
        end
        if (issue_valid !== (exp_slot >= 0)) begin
            report_error(1'b1, $sformatf("issue_valid %0b expected %0b", issue_valid,
                                         exp_slot >= 0));
        end
        if (issue_valid && exp_slot >= 0) begin
            t = slot_tag[exp_slot];
            compare_issue(issue, exp_issue[t]);
            slot_used[exp_slot] = 1'b0;
            rng    = xorshift32(rng);
            due[t] = cycle + tag_delay[t] + int'(rng % 32'd3);
            rs_cnt--;
        end
        if (retire.valid) begin
            if (retire_q.size() == 0) begin
                report_error(1'b0, "retire while nothing is in flight");
            end else begin
                exp_ret = retire_q.pop_front();
                compare_retire(retire, exp_ret);
                if (!cdb_seen[exp_ret.tag]) begin
                    report_error(1'b0, $sformatf("tag %0d retired before completion",
                                                 exp_ret.tag));
                end
                if (exp_ret.has_dest && shadow_map[exp_ret.dest_idx].valid &&
                    shadow_map[exp_ret.dest_idx].tag == exp_ret.tag) begin
                    shadow_map[exp_ret.dest_idx] = '0;
                end
                rob_cnt--;
            end
        end
        if (cdb.valid) begin
            cdb_seen[cdb.tag] = 1'b1;
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                if (exp_issue[i].rs1_tag.valid && exp_issue[i].rs1_tag.tag == cdb.tag) begin
                    src1_wait[i] = 1'b0;
                end
                if (exp_issue[i].rs2_tag.valid && exp_issue[i].rs2_tag.tag == cdb.tag) begin
                    src2_wait[i] = 1'b0;
                end
            end
        end
        if (dispatch_req.valid && dispatch_ready) begin
            t            = next_tag;
            exp_issue[t] = '{rob_tag: t, rs1_tag: look1, rs2_tag: look2};
            src1_wait[t] = look1.valid && !cdb_seen[look1.tag];
            src2_wait[t] = look2.valid && !cdb_seen[look2.tag];
            cdb_seen[t]  = 1'b0;
            tag_delay[t] = cur_delay;
            if (free_slot >= 0) begin
                slot_used[free_slot] = 1'b1;
                slot_tag[free_slot]  = t;
            end
            retire_q.push_back('{valid: 1'b1, tag: t, has_dest: dispatch_req.has_dest,
                                 dest_idx: dispatch_req.dest_idx});
            if (dispatch_req.has_dest) begin
                shadow_map[dispatch_req.dest_idx] = '{valid: 1'b1, tag: t};
            end
            next_tag = (t == `ROB_TAG_LEN'(`ROB_DEPTH - 1)) ? '0 : t + 1'b1;
            rob_cnt++;
            rs_cnt++;
            accepted = 1'b1;
        end
        if (squash) begin
            clear_model();
        end
        @(posedge clock);
        #0.5;
        pick = -1;
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            if (due[i] >= 0 && due[i] <= cycle + 1 && (pick < 0 || due[i] < due[pick])) begin
                pick = i; // earliest due first, one per cycle
            end
        end
        cdb = '0;
        if (pick >= 0) begin
            cdb       = '{valid: 1'b1, tag: `ROB_TAG_LEN'(pick)};
            due[pick] = -1;
        end
    endtask

    task automatic finish_test(input int id, input int err_start);
        while (retire_q.size() != 0) begin
            run_cycle();
        end
        repeat (2) run_cycle();
        if (id == 5 && (rs_stalls == 0 || rob_stalls == 0)) begin
            report_error(1'b0, "dispatch_ready never dropped for a full station and a full ROB");
        end
        if (errors == err_start) begin
            passed++;
            $display("test %0d (%s): passed", id, test_name[id - 1]);
        end else begin
            failed++;
            $display("test %0d (%s): failed with %0d errors", id, test_name[id - 1],
                     errors - err_start);
        end
    endtask

    initial begin
        int err_start;
        arst_n       = 1'b0;
        squash       = 1'b0;
        dispatch_req = '0;
        cdb          = '0;
        accepted     = 1'b0;
        cur_delay    = 1;
        clear_model();
        for (int i = 0; i < 10; i++) begin
            add_row(2, 1'b1, i + 1, 0, 31, 1 + i % 3, 1'b0); // wraps the tag space
        end
        add_row(3, 1'b1, 1, 0, 0, 4, 1'b0);
        add_row(3, 1'b1, 2, 1, 1, 2, 1'b0);
        add_row(3, 1'b1, 3, 2, 1, 3, 1'b0);
        add_row(3, 1'b1, 4, 3, 2, 1, 1'b0);
        add_row(3, 1'b1, 1, 4, 31, 2, 1'b0); // r1 renamed again
        add_row(3, 1'b1, 5, 1, 3, 1, 1'b0);
        add_row(4, 1'b1, 7, 0, 0, 12, 1'b0); // slow head
        add_row(4, 1'b1, 8, 0, 0, 1, 1'b0);
        add_row(4, 1'b0, 9, 7, 8, 2, 1'b0);
        add_row(4, 1'b1, 9, 8, 0, 1, 1'b0);
        add_row(4, 1'b1, 10, 0, 0, 6, 1'b0);
        add_row(5, 1'b1, 11, 0, 0, 30, 1'b0); // held producer
        for (int i = 0; i < `RS_DEPTH; i++) begin
            add_row(5, 1'b1, 12 + i, 11, 0, 1, 1'b0);
        end
        for (int i = 0; i <= `ROB_DEPTH; i++) begin
            add_row(5, 1'b1, 16 + i, 0, 0, 30, 1'b0);
        end
        add_row(6, 1'b1, 3, 0, 0, 20, 1'b0);
        add_row(6, 1'b1, 4, 3, 0, 1, 1'b0);
        add_row(6, 1'b1, 5, 3, 4, 1, 1'b0);
        add_row(6, 1'b1, 6, 3, 4, 1, 1'b1); // squash first, sources read back invalid
        add_row(6, 1'b1, 7, 6, 5, 2, 1'b0);
        add_row(6, 1'b1, 3, 7, 6, 1, 1'b0);
        cycle_limit = 40 * rows.size() + 200;

        repeat (16) @(posedge clock);
        #0.5;
        arst_n    = 1'b1;
        err_start = errors;
        repeat (20) run_cycle();
        finish_test(1, err_start);
        for (int r = 0; r < rows.size(); r++) begin
            if (r == 0 || rows[r].test_id != rows[r - 1].test_id) begin
                err_start = errors;
            end
            if (rows[r].squash_before) begin
                squash = 1'b1;
                cdb    = '0;
                run_cycle();
                squash = 1'b0;
            end
            dispatch_req = '{valid: 1'b1, has_dest: rows[r].has_dest, dest_idx: rows[r].dest,
                             rs1_idx: rows[r].rs1, rs2_idx: rows[r].rs2};
            cur_delay    = rows[r].cdb_delay;
            accepted     = 1'b0;
            while (!accepted) begin
                run_cycle();
            end
            dispatch_req = '0;
            if (r == rows.size() - 1 || rows[r + 1].test_id != rows[r].test_id) begin
                finish_test(rows[r].test_id, err_start);
            end
        end
        $display("tests passed %0d, failed %0d, errors %0d", passed, failed, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* dispatch_core.f */
+incdir+src
src/ooo_pkg.sv
src/map_table.sv
src/reorder_buffer.sv
src/reservation_station.sv
src/dispatch_core.sv
tb/dispatch_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# build with verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module dispatch_core_tb \
    -f dispatch_core.f -o dispatch_core_sim \
    && ./obj_dir/dispatch_core_sim | tee /dev/stderr \
        | grep -x "Test completed successfully" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
